// ==== hdl/cpc_pkg.sv ====
package cpc_pkg;

	//////////////////////////////////////////////////
	// Widths

	localparam int BOOT_ADDR_W  = 23;  // External memory address
	localparam int IOCTL_ADDR_W = 25;
	localparam int PAGE_W       = 9;   // High-ROM flag plus 8-bit page
	localparam int PAGE_OFS_W   = 14;  // 16 KB page
	localparam int MF2_RAM_AW   = 13;  // 8 KB cartridge RAM

	// Download index codes
	localparam logic [7:0] IDX_ROM = 8'd0;
	localparam logic [7:0] IDX_EXT = 8'd3;

	//////////////////////////////////////////////////
	// Target pages in external memory

	localparam logic [PAGE_W-1:0] PAGE_OS     = 9'h000;
	localparam logic [PAGE_W-1:0] PAGE_BASIC  = 9'h100;
	localparam logic [PAGE_W-1:0] PAGE_AMSDOS = 9'h107;
	localparam logic [PAGE_W-1:0] PAGE_MF2    = 9'h0FF;
	localparam logic [PAGE_W-1:0] PAGE_BAD    = 9'h1EE;  // Unused page for bad extensions

	//////////////////////////////////////////////////
	// Cartridge shadow locations

	localparam logic [MF2_RAM_AW-1:0] MF2_ADDR_PEN_IDX   = 13'h1FCF;
	localparam logic [MF2_RAM_AW-1:0] MF2_ADDR_PEN_BASE  = 13'h1F90;
	localparam logic [MF2_RAM_AW-1:0] MF2_ADDR_BORDER    = 13'h1FDF;
	localparam logic [MF2_RAM_AW-1:0] MF2_ADDR_MODE      = 13'h1FEF;
	localparam logic [MF2_RAM_AW-1:0] MF2_ADDR_BANK      = 13'h1FFF;
	localparam logic [MF2_RAM_AW-1:0] MF2_ADDR_CRTC_SEL  = 13'h1CFF;
	localparam logic [MF2_RAM_AW-1:0] MF2_ADDR_CRTC_BASE = 13'h1DB0;
	localparam logic [MF2_RAM_AW-1:0] MF2_ADDR_PPI       = 13'h17FF;
	localparam logic [MF2_RAM_AW-1:0] MF2_ADDR_ROMSEL    = 13'h1AAC;

	// I/O port high address bytes
	localparam logic [7:0] PORT_GA       = 8'h7F;
	localparam logic [7:0] PORT_CRTC_SEL = 8'hBC;
	localparam logic [7:0] PORT_CRTC_VAL = 8'hBD;
	localparam logic [7:0] PORT_PPI      = 8'hF7;
	localparam logic [7:0] PORT_ROMSEL   = 8'hDF;

	// Fetch addresses and page-in port
	localparam logic [15:0] NMI_VECTOR    = 16'h0066;
	localparam logic [15:0] MF2_HIDE_ADDR = 16'h0065;
	localparam logic [15:0] MF2_PORT_BASE = 16'hFEE8;  // FEE8 in, FEEA out

	//////////////////////////////////////////////////
	// Download address, seen as slot or as page offset

	typedef struct packed {
		logic [IOCTL_ADDR_W-PAGE_OFS_W-1:0] slot;
		logic [PAGE_OFS_W-1:0]              ofs;
	} ioctl_rom_t;

	typedef struct packed {
		logic [2:0]            unused;
		logic [7:0]            page_ofs;
		logic [PAGE_OFS_W-1:0] ofs;
	} ioctl_ext_t;

	typedef union packed {
		ioctl_rom_t rom;
		ioctl_ext_t ext;
	} ioctl_addr_u;

endpackage

// ==== hdl/cpc_bus_if.sv ====
interface cpc_bus_if;
	import cpc_pkg::*;

	logic [15:0]            cpu_addr;
	logic [7:0]             cpu_dout;
	logic [BOOT_ADDR_W-1:0] ram_a;     // CPU memory address after banking
	logic                   io_wr;
	logic                   mem_rd;
	logic                   mem_wr;
	logic                   m1;        // Opcode fetch

	// Cartridge control, NMI and paging
	modport ctl (
		input cpu_addr,
		input cpu_dout,
		input io_wr,
		input m1
	);

	// Shadow RAM and register capture
	modport shadow (
		input cpu_addr,
		input cpu_dout,
		input ram_a,
		input io_wr,
		input mem_rd,
		input mem_wr
	);

endinterface

// ==== hdl/rom_loader.sv ====
module rom_loader (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic                           ioctl_download,
	input  logic [7:0]                     ioctl_index,
	input  logic                           ioctl_wr,
	input  cpc_pkg::ioctl_addr_u           ioctl_addr,
	input  logic [15:0]                    ioctl_file_ext,
	input  logic                           model,
	output logic                           boot_active,
	output logic                           boot_we,
	output logic [cpc_pkg::BOOT_ADDR_W-1:0] boot_addr,
	output logic [1:0]                     boot_bank,
	output logic [255:0]                   rom_map
);
	import cpc_pkg::*;

	logic              rom_download;
	logic              ext_download;
	logic              old_download;
	logic              old_wr;
	logic              slot_ok;
	logic [PAGE_W-1:0] page;      // Expansion target page
	logic [PAGE_W-1:0] ext_page;
	logic [4:0]        hex_hi;    // Valid flag and nibble
	logic [4:0]        hex_lo;
	logic [7:0]        ext_hi;

	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		logic [4:0] res;
		res = 5'h00;
		if (c >= "0" && c <= "9")
			res = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			res = {1'b1, c[3:0] + 4'd9};
		return res;
	endfunction

	assign rom_download = ioctl_download && (ioctl_index == IDX_ROM);
	assign ext_download = ioctl_download && (ioctl_index == IDX_EXT);
	assign boot_active  = rom_download | ext_download;
	assign boot_we      = boot_active & ioctl_wr & slot_ok;

	//////////////////////////////////////////////////
	// Expansion page from the file extension

	always_comb begin
		hex_hi = hex_digit(ioctl_file_ext[15:8]);
		hex_lo = hex_digit(ioctl_file_ext[7:0]);
		if (ioctl_file_ext == "ZZ")
			ext_page = '0;
		else if (hex_hi[4] && hex_lo[4])
			ext_page = {1'b1, hex_hi[3:0], hex_lo[3:0]};  // High ROM area
		else
			ext_page = PAGE_BAD;
	end

	always_ff @(posedge clk_sys) begin
		if (ext_download && !old_download)
			page <= ext_page;
	end

	//////////////////////////////////////////////////
	// Boot address and bank

	// Lower 4 MB holds OS, RAM and cartridge ROM, upper 4 MB the high ROMs
	always_comb begin
		slot_ok   = 1'b1;
		boot_bank = 2'b00;
		ext_hi    = page[7:0] + ioctl_addr.ext.page_ofs;
		boot_addr = {{PAGE_W{1'b1}}, ioctl_addr.rom.ofs};
		if (ext_download) begin
			boot_addr = {page[PAGE_W-1], ext_hi, ioctl_addr.ext.ofs};
			boot_bank = {1'b0, model};
		end else begin
			case (ioctl_addr.rom.slot)
				11'd0, 11'd4: boot_addr[BOOT_ADDR_W-1 -: PAGE_W] = PAGE_OS;
				11'd1, 11'd5: boot_addr[BOOT_ADDR_W-1 -: PAGE_W] = PAGE_BASIC;
				11'd2, 11'd6: boot_addr[BOOT_ADDR_W-1 -: PAGE_W] = PAGE_AMSDOS;
				11'd3, 11'd7: boot_addr[BOOT_ADDR_W-1 -: PAGE_W] = PAGE_MF2;
				default:      slot_ok = 1'b0;  // No target
			endcase
			if (slot_ok)
				boot_bank = {1'b0, ioctl_addr.rom.slot[2]};  // 664 images in bank 1
		end
	end

	//////////////////////////////////////////////////
	// Loaded high-ROM map

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			old_wr       <= 1'b0;
			rom_map      <= '0;
		end else begin
			old_download <= ioctl_download;
			old_wr       <= ioctl_wr;
			// Mark the page once its byte has gone out
			if (boot_active && slot_ok && old_wr && !ioctl_wr && boot_addr[BOOT_ADDR_W-1])
				rom_map[boot_addr[BOOT_ADDR_W-2 -: 8]] <= 1'b1;
		end
	end

endmodule

// ==== hdl/mf2_control.sv ====
module mf2_control (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       key_nmi,
	input  logic [1:0] st_mf2,     // 0 enabled, 1 hidden, 2 disabled
	cpc_bus_if.ctl     bus,
	output logic       mf2_nmi,
	output logic       mf2_en,
	output logic       mf2_ram_en,
	output logic       mf2_rom_en
);
	import cpc_pkg::*;

	logic old_key_nmi;
	logic old_m1;
	logic old_io_wr;
	logic mf2_hidden;
	logic nmi_req;
	logic nmi_fetch;
	logic hide_fetch;
	logic port_wr;

	assign nmi_req    = key_nmi & ~old_key_nmi & ~mf2_en & ~st_mf2[1];
	assign nmi_fetch  = bus.m1 & ~old_m1 & mf2_nmi & (bus.cpu_addr == NMI_VECTOR);
	assign hide_fetch = bus.m1 & ~old_m1 & mf2_en & (bus.cpu_addr == MF2_HIDE_ADDR);

	// FEE8 pages in, FEEA pages out
	assign port_wr = bus.io_wr & ~old_io_wr &
		(bus.cpu_addr[15:2] == MF2_PORT_BASE[15:2]);

	//////////////////////////////////////////////////
	// NMI, enable and hidden state

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_key_nmi <= 1'b0;
			old_m1      <= 1'b0;
			old_io_wr   <= 1'b0;
			mf2_nmi     <= 1'b0;
			mf2_en      <= 1'b0;
			mf2_hidden  <= |st_mf2;
		end else begin
			old_key_nmi <= key_nmi;
			old_m1      <= bus.m1;
			old_io_wr   <= bus.io_wr;

			if (nmi_req)
				mf2_nmi <= 1'b1;

			if (nmi_fetch) begin  // Cartridge takes over on the NMI fetch
				mf2_en     <= 1'b1;
				mf2_hidden <= 1'b0;
				mf2_nmi    <= 1'b0;
			end

			if (hide_fetch)
				mf2_hidden <= 1'b1;

			if (port_wr) begin
				mf2_en <= ~bus.cpu_addr[1] & ~mf2_hidden & ~st_mf2[1];
				if (!bus.cpu_addr[1])
					mf2_nmi <= 1'b0;  // Page-in serves a pending request
			end
		end
	end

	// ROM at 0000-1FFF, RAM at 2000-3FFF
	assign mf2_rom_en = mf2_en & (bus.cpu_addr[15:13] == 3'b000);
	assign mf2_ram_en = mf2_en & (bus.cpu_addr[15:13] == 3'b001);

endmodule

// ==== hdl/mf2_shadow_ram.sv ====
module mf2_shadow_ram (
	input  logic       clk_sys,
	input  logic       mf2_ram_en,
	cpc_bus_if.shadow  bus,
	output logic [7:0] mf2_dout
);
	import cpc_pkg::*;

	logic [7:0]            ram [0:(2**MF2_RAM_AW)-1];
	logic                  old_io_wr;
	logic [4:0]            pen_index;   // Last gate-array pen select
	logic [3:0]            crtc_reg;    // Last CRTC register select
	logic [MF2_RAM_AW-1:0] store_addr;
	logic                  store_hit;
	logic [MF2_RAM_AW-1:0] ram_addr;
	logic [7:0]            ram_din;
	logic                  ram_we;
	logic [7:0]            ram_q;

	//////////////////////////////////////////////////
	// Shadow location for the port being written

	always_comb begin
		store_hit  = 1'b1;
		store_addr = '0;
		case (bus.cpu_addr[15:8])
			PORT_GA: begin
				case (bus.cpu_dout[7:6])  // Gate-array function bits
					2'b00: store_addr = MF2_ADDR_PEN_IDX;
					2'b01: store_addr = pen_index[4] ? MF2_ADDR_BORDER :
						{MF2_ADDR_PEN_BASE[MF2_RAM_AW-1:4], pen_index[3:0]};
					2'b10: store_addr = MF2_ADDR_MODE;
					default: store_addr = MF2_ADDR_BANK;
				endcase
			end
			PORT_CRTC_SEL: store_addr = MF2_ADDR_CRTC_SEL;
			PORT_CRTC_VAL: store_addr = {MF2_ADDR_CRTC_BASE[MF2_RAM_AW-1:4], crtc_reg};
			PORT_PPI:      store_addr = MF2_ADDR_PPI;
			PORT_ROMSEL:   store_addr = MF2_ADDR_ROMSEL;
			default:       store_hit = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////
	// RAM port request

	always_ff @(posedge clk_sys) begin
		old_io_wr <= bus.io_wr;
		if (bus.io_wr && !old_io_wr && store_hit) begin
			if (bus.cpu_addr[15:8] == PORT_GA && bus.cpu_dout[7:6] == 2'b00)
				pen_index <= bus.cpu_dout[4:0];
			if (bus.cpu_addr[15:8] == PORT_CRTC_SEL)
				crtc_reg <= bus.cpu_dout[3:0];
			ram_addr <= store_addr;
			ram_din  <= bus.cpu_dout;
			ram_we   <= 1'b1;
		end else if (bus.mem_wr && mf2_ram_en) begin  // CPU write into the window
			ram_addr <= bus.ram_a[MF2_RAM_AW-1:0];
			ram_din  <= bus.cpu_dout;
			ram_we   <= 1'b1;
		end else begin
			ram_addr <= bus.ram_a[MF2_RAM_AW-1:0];
			ram_we   <= 1'b0;
		end
	end

	// 8 KB RAM, write-through on the read port
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_addr] <= ram_din;
			ram_q         <= ram_din;
		end else begin
			ram_q <= ram[ram_addr];
		end
	end

	assign mf2_dout = (mf2_ram_en && bus.mem_rd) ? ram_q : 8'hFF;  // Wired-AND bus idle

endmodule

// ==== hdl/cpc_glue_top.sv ====
module cpc_glue_top (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic                            ioctl_download,
	input  logic [7:0]                      ioctl_index,
	input  logic                            ioctl_wr,
	input  logic [cpc_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]                      ioctl_dout,
	input  logic [15:0]                     ioctl_file_ext,
	input  logic                            st_cpc664,
	input  logic [1:0]                      st_mf2,
	input  logic                            key_nmi,
	input  logic                            key_reset,
	input  logic [15:0]                     cpu_addr,
	input  logic [7:0]                      cpu_dout,
	input  logic [cpc_pkg::BOOT_ADDR_W-1:0]  ram_a,
	input  logic                            io_wr,
	input  logic                            mem_rd,
	input  logic                            mem_wr,
	input  logic                            m1,
	output logic                            machine_reset,
	output logic                            model,
	output logic [255:0]                    rom_map,
	output logic                            sdram_we,
	output logic                            sdram_oe,
	output logic [cpc_pkg::BOOT_ADDR_W-1:0]  sdram_addr,
	output logic [1:0]                      sdram_bank,
	output logic [7:0]                      sdram_din,
	output logic                            mf2_nmi,
	output logic [7:0]                      mf2_dout
);
	import cpc_pkg::*;

	logic                   boot_active;
	logic                   boot_we;
	logic [BOOT_ADDR_W-1:0] boot_addr;
	logic [1:0]             boot_bank;
	logic                   mf2_ram_en;
	logic                   mf2_rom_en;

	cpc_bus_if cpu_bus ();

	assign cpu_bus.cpu_addr = cpu_addr;
	assign cpu_bus.cpu_dout = cpu_dout;
	assign cpu_bus.ram_a    = ram_a;
	assign cpu_bus.io_wr    = io_wr;
	assign cpu_bus.mem_rd   = mem_rd;
	assign cpu_bus.mem_wr   = mem_wr;
	assign cpu_bus.m1       = m1;

	rom_loader i_rom_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_file_ext (ioctl_file_ext),
		.model          (model),
		.boot_active    (boot_active),
		.boot_we        (boot_we),
		.boot_addr      (boot_addr),
		.boot_bank      (boot_bank),
		.rom_map        (rom_map)
	);

	mf2_control i_mf2_control (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.key_nmi    (key_nmi),
		.st_mf2     (st_mf2),
		.bus        (cpu_bus.ctl),
		.mf2_nmi    (mf2_nmi),
		.mf2_en     (),            // Paging is seen through the window enables
		.mf2_ram_en (mf2_ram_en),
		.mf2_rom_en (mf2_rom_en)
	);

	mf2_shadow_ram i_mf2_shadow_ram (
		.clk_sys    (clk_sys),
		.mf2_ram_en (mf2_ram_en),
		.bus        (cpu_bus.shadow),
		.mf2_dout   (mf2_dout)
	);

	//////////////////////////////////////////////////
	// Machine reset and model latch

	always_ff @(posedge clk_sys) begin
		machine_reset <= reset | key_reset | boot_active;
		if (machine_reset)
			model <= st_cpc664;  // Model change applies on reset only
	end

	//////////////////////////////////////////////////
	// Memory request mux

	always_comb begin
		if (machine_reset) begin  // Boot writes own the memory
			sdram_we   = boot_we;
			sdram_oe   = 1'b0;
			sdram_addr = boot_addr;
			sdram_bank = boot_bank;
			sdram_din  = ioctl_dout;
		end else begin
			sdram_we   = mem_wr & ~mf2_ram_en & ~mf2_rom_en;
			sdram_oe   = mem_rd & ~mf2_ram_en;
			sdram_addr = mf2_rom_en ? {PAGE_MF2, cpu_addr[PAGE_OFS_W-1:0]} : ram_a;
			sdram_bank = {1'b0, model};
			sdram_din  = cpu_dout;
		end
	end

endmodule

// ==== dv/mf2_checker.sv ====
module mf2_checker (
	input logic       clk_sys,
	input logic       reset,
	input logic [1:0] st_mf2,
	input logic       mf2_nmi,
	input logic       mf2_en,
	input logic       mf2_ram_en,
	input logic       mf2_rom_en
);
	timeunit 1ns;
	timeprecision 100ps;

	//////////////////////////////////////////////////
	// Cartridge control rules

	// No NMI request with the cartridge disabled
	nmi_when_disabled: assert property (@(posedge clk_sys) disable iff (reset)
		st_mf2[1] |-> !$rose(mf2_nmi))
		else $error("mf2_nmi rose while the cartridge is disabled");

	nmi_after_page_in: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(mf2_en) |=> !mf2_nmi)  // Request served by the page-in
		else $error("mf2_nmi still high one cycle after mf2_en rose");

	window_overlap: assert property (@(posedge clk_sys) disable iff (reset)
		!(mf2_rom_en && mf2_ram_en))
		else $error("ROM and RAM windows enabled together");

endmodule

bind mf2_control mf2_checker i_mf2_checker (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.st_mf2     (st_mf2),
	.mf2_nmi    (mf2_nmi),
	.mf2_en     (mf2_en),
	.mf2_ram_en (mf2_ram_en),
	.mf2_rom_en (mf2_rom_en)
);

// ==== dv/tb_cpc_glue.sv ====
module tb_cpc_glue;
	timeunit 1ns;
	timeprecision 100ps;
	import cpc_pkg::*;

	localparam int WAIT_LIMIT = 40;  // Cycles allowed per wait loop

	logic                    clk_sys;
	logic                    reset;
	logic                    ioctl_download;
	logic [7:0]              ioctl_index;
	logic                    ioctl_wr;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [7:0]              ioctl_dout;
	logic [15:0]             ioctl_file_ext;
	logic                    st_cpc664;
	logic [1:0]              st_mf2;
	logic                    key_nmi;
	logic                    key_reset;
	logic [15:0]             cpu_addr;
	logic [7:0]              cpu_dout;
	logic [BOOT_ADDR_W-1:0]  ram_a;
	logic                    io_wr;
	logic                    mem_rd;
	logic                    mem_wr;
	logic                    m1;
	logic                    machine_reset;
	logic                    model;
	logic [255:0]            rom_map;
	logic                    sdram_we;
	logic                    sdram_oe;
	logic [BOOT_ADDR_W-1:0]  sdram_addr;
	logic [1:0]              sdram_bank;
	logic [7:0]              sdram_din;
	logic                    mf2_nmi;
	logic [7:0]              mf2_dout;

	int          fd;
	int          n;
	string       line;
	int          test;
	logic [31:0] op, a0, a1, a2, e0, e1, e2;
	int          cur_test;
	int          test_errors;
	int          total_errors;
	int          tests_run;
	int          tests_failed;

	cpc_glue_top i_cpc_glue_top (.*);

	always #50 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// Helpers

	task automatic step_cycle();
		@(posedge clk_sys);
		#10;  // Drive point after the edge
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("** Error at %0d ns: test %0d, %s is %h, expected %h",
				$time, cur_test, what, got, exp);
			test_errors++;
		end
	endtask

	task automatic wait_machine_reset(input logic level);
		int cnt;
		cnt = 0;
		while (machine_reset !== level && cnt < WAIT_LIMIT) begin
			step_cycle();
			cnt++;
		end
		assert (machine_reset === level) else begin
			$display("Timeout in test %0d: machine_reset never reached %0b", cur_test, level);
			test_errors++;
		end
	endtask

	task automatic finish_test();
		tests_run++;
		total_errors += test_errors;
		if (test_errors == 0)
			$display("Test %0d: passed", cur_test);
		else begin
			$display("Test %0d: failed with %0d errors", cur_test, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	//////////////////////////////////////////////////
	// One golden record

	task automatic run_record(input logic [7:0] code);
		case (code)
			8'h01: begin  // Download start
				ioctl_index    = a0[7:0];
				ioctl_file_ext = a1[15:0];
				ioctl_download = 1'b1;
				wait_machine_reset(1'b1);
			end
			8'h02: begin  // Download byte
				ioctl_addr = a0[IOCTL_ADDR_W-1:0];
				ioctl_dout = a0[7:0] ^ 8'h5A;
				ioctl_wr   = 1'b1;
				#5;
				check_value("sdram_we", 32'(sdram_we), e0);
				check_value("sdram_oe", 32'(sdram_oe), 32'd0);
				if (e0[0]) begin  // Address only matters for a real write
					check_value("sdram_addr", 32'(sdram_addr), e1);
					check_value("sdram_bank", 32'(sdram_bank), e2);
					check_value("sdram_din", 32'(sdram_din), 32'(ioctl_dout));
				end
				step_cycle();
				ioctl_wr = 1'b0;
				step_cycle();
				step_cycle();
			end
			8'h03: begin  // Download end
				ioctl_download = 1'b0;
				wait_machine_reset(1'b0);
				repeat (3) step_cycle();
			end
			8'h04: check_value("rom_map bit", 32'(rom_map[a0[7:0]]), e0);
			8'h05: begin
				st_cpc664 = a0[0];
				st_mf2    = a1[1:0];
				step_cycle();
			end
			8'h06: begin
				key_reset = a0[0];
				wait_machine_reset(a0[0]);
			end
			8'h07: begin
				check_value("model", 32'(model), e0);
				check_value("sdram_bank", 32'(sdram_bank), e1);
			end
			8'h08: begin  // Key press
				key_nmi = 1'b1;
				step_cycle();
				check_value("mf2_nmi", 32'(mf2_nmi), e0);
				key_nmi = 1'b0;
				step_cycle();
			end
			8'h09: begin  // Opcode fetch
				cpu_addr = a0[15:0];
				m1       = 1'b1;
				step_cycle();
				check_value("mf2_nmi", 32'(mf2_nmi), e0);
				m1 = 1'b0;
				step_cycle();
			end
			8'h0A: begin  // Port write
				cpu_addr = a0[15:0];
				cpu_dout = a1[7:0];
				io_wr    = 1'b1;
				step_cycle();
				io_wr = 1'b0;
				step_cycle();
				step_cycle();
			end
			8'h0B: begin  // CPU memory request
				cpu_addr = a0[15:0];
				ram_a    = a1[BOOT_ADDR_W-1:0];
				cpu_dout = 8'h3C;
				mem_rd   = a2[1];
				mem_wr   = a2[0];
				#5;
				check_value("sdram_we", 32'(sdram_we), e0);
				check_value("sdram_oe", 32'(sdram_oe), e1);
				check_value("sdram_addr", 32'(sdram_addr), e2);
				step_cycle();
				mem_rd = 1'b0;
				mem_wr = 1'b0;
				step_cycle();
			end
			8'h0C: begin  // Cartridge RAM read, three cycles
				cpu_addr = a0[15:0];
				ram_a    = a1[BOOT_ADDR_W-1:0];
				mem_rd   = 1'b1;
				repeat (3) step_cycle();
				check_value("mf2_dout", 32'(mf2_dout), e0);
				mem_rd = 1'b0;
				step_cycle();
			end
			default: begin
				$display("Unknown operation %h in test %0d", code, cur_test);
				test_errors++;
			end
		endcase
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		clk_sys        = 1'b0;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_file_ext = '0;
		st_cpc664      = 1'b0;
		st_mf2         = 2'd0;
		key_nmi        = 1'b0;
		key_reset      = 1'b0;
		cpu_addr       = '0;
		cpu_dout       = '0;
		ram_a          = '0;
		io_wr          = 1'b0;
		mem_rd         = 1'b0;
		mem_wr         = 1'b0;
		m1             = 1'b0;
		cur_test       = 0;
		test_errors    = 0;
		total_errors   = 0;
		tests_run      = 0;
		tests_failed   = 0;

		repeat (5) @(posedge clk_sys);
		#10;
		reset = 1'b0;
		wait_machine_reset(1'b0);
		total_errors += test_errors;
		test_errors = 0;

		fd = $fopen("dv/cpc_glue_golden.txt", "r");
		assert (fd != 0) else begin
			$display("Could not open dv/cpc_glue_golden.txt");
			total_errors++;
		end
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 3 || line.getc(0) == "#")
					continue;  // Blank or comment
				n = $sscanf(line, "%d %h %h %h %h %h %h %h", test, op, a0, a1, a2, e0, e1, e2);
				if (n != 8) begin
					$display("Malformed golden line: %s", line);
					total_errors++;
					continue;
				end
				if (test != cur_test) begin
					if (cur_test != 0)
						finish_test();
					cur_test = test;
				end
				run_record(op[7:0]);
			end
			$fclose(fd);
			if (cur_test != 0)
				finish_test();
		end

		$display("Summary: %0d tests run, %0d failed, %0d errors",
			tests_run, tests_failed, total_errors);
		if (total_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== dv/cpc_glue_golden.txt ====
# test(dec) op a0 a1 a2 exp0 exp1 exp2 (hex). ops: 01 dl start, 02 dl byte, 03 dl end,
# 04 rom_map bit, 05 settings, 06 key_reset, 07 model, 08 key_nmi, 09 fetch, 0A io, 0B mem, 0C mf2 read
1 05 0 0 0 0 0 0
1 01 0 0 0 1 0 0
1 02 000010 0 0 1 000010 0
1 02 004020 0 0 1 400020 0
1 02 00BFFF 0 0 1 41FFFF 0
1 02 00C001 0 0 1 3FC001 0
1 02 010002 0 0 1 000002 1
1 02 014100 0 0 1 400100 1
1 02 018000 0 0 1 41C000 1
1 02 01D234 0 0 1 3FD234 1
1 02 020000 0 0 0 0 0
1 03 0 0 0 0 0 0
1 04 00 0 0 1 0 0
1 04 07 0 0 1 0 0
1 04 FF 0 0 0 0 0
2 01 3 3141 0 1 0 0
2 02 008055 0 0 1 470055 0
2 03 0 0 0 0 0 0
2 04 1C 0 0 1 0 0
2 04 1A 0 0 0 0 0
2 01 3 5A5A 0 1 0 0
2 02 004010 0 0 1 004010 0
2 03 0 0 0 0 0 0
2 01 3 5137 0 1 0 0
2 02 000003 0 0 1 7B8003 0
2 03 0 0 0 0 0 0
2 04 EE 0 0 1 0 0
3 05 1 0 0 0 0 0
3 07 0 0 0 0 0 0
3 06 1 0 0 1 0 0
3 06 0 0 0 0 0 0
3 07 0 0 0 1 1 0
4 08 0 0 0 1 0 0
4 09 0066 0 0 0 0 0
4 0B 0123 000123 1 0 0 3FC123
4 0B 2000 002000 2 0 0 002000
4 0A FEEA 00 0 0 0 0
4 0B 0123 000123 2 0 1 000123
4 0B 0123 000123 1 1 0 000123
5 0A 7F00 8C 0 0 0 0
5 0A BC00 05 0 0 0 0
5 0A FEE8 00 0 0 0 0
5 0C 3FEF 003FEF 0 8C 0 0
5 0C 3CFF 003CFF 0 05 0 0
5 0A FEEA 00 0 0 0 0
6 05 1 2 0 0 0 0
6 08 0 0 0 0 0 0
6 0A FEE8 00 0 0 0 0
6 0B 0123 000123 1 1 0 000123
6 0B 2000 002000 2 0 1 002000

// ==== compile.f ====
hdl/cpc_pkg.sv
hdl/cpc_bus_if.sv
hdl/rom_loader.sv
hdl/mf2_control.sv
hdl/mf2_shadow_ram.sv
hdl/cpc_glue_top.sv
dv/mf2_checker.sv
dv/tb_cpc_glue.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpc_glue
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TESTS FAILED
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
